/* bench/bank_arb_asserts.sv */
/*
  Protocol checks bound into the arbiter top level.
  Pending state is rebuilt from the per-bank request bitmaps, so a slot
  whose bank field is out of range is not seen here.
*/

`timescale 1ns/1ps

module bank_arb_asserts
  import bank_arb_pkg::*;
#(
  parameter int N_MASTERS = n_masters,
  parameter int N_BANKS   = n_banks
) (
  input logic                              clk,
  input logic                              rst_n,
  input logic [N_MASTERS-1:0]              req_valid,
  input logic [N_BANKS-1:0][N_MASTERS-1:0] pick,
  input logic [N_BANKS-1:0][N_MASTERS-1:0] bank_req,
  input logic [N_BANKS-1:0]                gnt_valid
);

  logic [N_MASTERS-1:0] pending_any;  // Master waits in some bank.

  always_comb begin
    pending_any = '0;
    for (int b = 0; b < N_BANKS; b++) begin
      pending_any = pending_any | bank_req[b];
    end
  end

  // Each arbiter names one winner at most.
  for (genvar b = 0; b < N_BANKS; b++) begin : g_pick
    a_pick_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(pick[b]))
      else $error("bank %0d picked more than one master", b);
  end

  // One outstanding request per master.
  a_no_restrobe: assert property (@(posedge clk) disable iff (!rst_n)
    (req_valid & pending_any) == '0)
    else $error("request strobe from a master that is still pending");

  // Outputs stay quiet while reset is held.
  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> gnt_valid == '0)
    else $error("gnt_valid high during reset");

endmodule : bank_arb_asserts

bind bank_arb_top bank_arb_asserts #(
  .N_MASTERS (N_MASTERS),
  .N_BANKS   (N_BANKS)
) u_asserts (
  .clk       (clk),
  .rst_n     (rst_n),
  .req_valid (req_valid),
  .pick      (pick),
  .bank_req  (bank_req),
  .gnt_valid (gnt_valid)
);

/* bench/bank_arb_tb.sv */
/*
  Testbench for the bank access arbiter at package default sizes.
  A cycle model of the pending slots, bank directions and output stage
  is stepped on every rising edge and compared on the falling edge.
  Inputs change 1 ns after the rising edge. Random traffic comes from an
  LCG, and a master is strobed only when it has no request outstanding.
  The directed order check assumes four masters.
*/

`timescale 1ns/1ps

module bank_arb_tb
  import bank_arb_pkg::*;
();

  localparam int random_cycles   = 400;
  localparam int directed_cycles = 60;
  localparam int cycle_limit     = 3 * (random_cycles + directed_cycles);

  // Reference state, one register stage per field group.
  typedef struct packed {
    logic [n_masters-1:0]  pending;     // Slot waits for a grant.
    req_t [n_masters-1:0]  slot;        // Captured requests.
    logic [n_banks-1:0]    high_first;  // Direction per bank.
    logic [n_banks-1:0]    arb_valid;   // Arbiter output stage.
    grant_t [n_banks-1:0]  arb_gnt;
    logic [n_banks-1:0]    gnt_valid;   // Collector output stage.
    grant_t [n_banks-1:0]  gnt;
    logic [n_masters-1:0]  done;
  } model_t;

  logic                 clk;
  logic                 rst_n;
  logic [n_masters-1:0] req_valid;
  req_t [n_masters-1:0] req;
  logic [n_banks-1:0]   gnt_valid;
  grant_t [n_banks-1:0] gnt;
  logic [n_masters-1:0] done;

  model_t      model;                       // Expected state after each edge.
  logic [31:0] rng;                         // LCG state.
  int          cycle = 0;                   // Rising edges since start.
  int          issued [n_masters];          // Strobes sent per master.
  int          completed [n_masters];       // Done strobes seen per master.
  int          last_done_cycle [n_masters];
  grant_t      seen_gnt [n_banks];          // Last valid grant per bank.
  master_id_t  bank0_log [$];               // Bank 0 winners in order.

  bank_arb_top #(
    .N_MASTERS (n_masters),
    .N_BANKS   (n_banks)
  ) u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .gnt_valid (gnt_valid),
    .gnt       (gnt),
    .done      (done)
  );

  always #5 clk = ~clk;  // 10 ns period.

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // One rising edge of the whole subsystem.
  function automatic model_t model_step(input model_t s, input logic [n_masters-1:0] v,
                                        input req_t [n_masters-1:0] r);
    model_t     nx;
    int         win;
    master_id_t wi;
    nx = s;
    // Collector copies last cycle's grants and decodes done.
    nx.gnt_valid = s.arb_valid;
    nx.done      = '0;
    for (int b = 0; b < n_banks; b++) begin
      if (s.arb_valid[b]) begin
        nx.gnt[b]                     = s.arb_gnt[b];
        nx.done[s.arb_gnt[b].master] = 1'b1;
      end
    end
    // Each bank serves the first pending master from its favoured end.
    for (int b = 0; b < n_banks; b++) begin
      win = -1;
      for (int k = 0; k < n_masters; k++) begin
        int m;
        m = s.high_first[b] ? n_masters - 1 - k : k;
        if (win < 0 && s.pending[m] && s.slot[m].bank == bank_id_t'(b)) win = m;
      end
      nx.arb_valid[b] = (win >= 0);
      if (win >= 0) begin
        wi                    = master_id_t'(win);
        nx.arb_gnt[b].master  = wi;
        nx.arb_gnt[b].data    = s.slot[wi].data;
        nx.high_first[b]      = ~s.high_first[b];  // Flip on grants only.
        nx.pending[wi]        = 1'b0;
      end
    end
    // New strobes load their slots.
    for (int m = 0; m < n_masters; m++) begin
      if (v[m]) begin
        nx.pending[m] = 1'b1;
        nx.slot[m]    = r[m];
      end
    end
    return nx;
  endfunction

  task automatic stop_with_failure();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped.");
  endtask

  task automatic report_error(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    stop_with_failure();
  endtask

  task automatic check_grant(input int b, input logic got_v, input grant_t got,
                             input logic exp_v, input grant_t exp);
    if (got_v !== exp_v) begin
      report_error($sformatf("bank %0d gnt_valid is %0b, expected %0b", b, got_v, exp_v));
    end else if (exp_v && got !== exp) begin
      report_error($sformatf("bank %0d grant is master %0d data %h, expected %0d %h",
                             b, got.master, got.data, exp.master, exp.data));
    end
  endtask

  task automatic check_done(input logic [n_masters-1:0] got, input logic [n_masters-1:0] exp);
    if (got !== exp) report_error($sformatf("done is %b, expected %b", got, exp));
  endtask

  // Model update and cycle count on the rising edge.
  always @(posedge clk) begin
    if (!rst_n) model <= '0;  // Idle, low-first.
    else model <= model_step(model, req_valid, req);
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
      stop_with_failure();
    end
  end

  // Compare in mid cycle, where every output is settled.
  always @(negedge clk) begin
    if (rst_n) begin
      for (int b = 0; b < n_banks; b++) begin
        check_grant(b, gnt_valid[b], gnt[b], model.gnt_valid[b], model.gnt[b]);
        if (gnt_valid[b]) seen_gnt[b] = gnt[b];
      end
      if (gnt_valid[0]) bank0_log.push_back(gnt[0].master);
      check_done(done, model.done);
      for (int m = 0; m < n_masters; m++) begin
        if (done[m]) begin
          if (completed[m] >= issued[m]) begin
            report_error($sformatf("done for master %0d with nothing outstanding", m));
          end
          completed[m]++;
          last_done_cycle[m] = cycle;
        end
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;  // Drive away from the edge.
  endtask

  task automatic apply_inputs(input logic [n_masters-1:0] v, input req_t [n_masters-1:0] r);
    req_valid = v;
    req       = r;
    for (int m = 0; m < n_masters; m++) begin
      if (v[m]) issued[m]++;
    end
  endtask

  // Keep inputs quiet until every request has its done.
  task automatic wait_idle();
    int busy;
    busy = 1;
    while (busy != 0) begin
      next_cycle();
      apply_inputs('0, '0);
      busy = 0;
      for (int m = 0; m < n_masters; m++) begin
        if (issued[m] != completed[m]) busy++;
      end
    end
  endtask

  // One request to an idle bank, fixed two-cycle latency.
  task automatic test_single();
    logic [n_masters-1:0] v;
    req_t [n_masters-1:0] r;
    grant_t               exp;
    int                   sample_cycle;
    v          = '0;
    r          = '0;
    v[1]       = 1'b1;
    r[1].bank  = bank_id_t'(0);
    r[1].data  = 16'ha5a5;
    exp.master = master_id_t'(1);
    exp.data   = 16'ha5a5;
    next_cycle();
    apply_inputs(v, r);
    sample_cycle = cycle + 1;  // Next edge samples it.
    wait_idle();
    if (last_done_cycle[1] - sample_cycle != 2) begin
      report_error($sformatf("latency %0d cycles, expected 2", last_done_cycle[1] - sample_cycle));
    end
    check_grant(0, 1'b1, seen_gnt[0], 1'b1, exp);
  endtask

  // All masters hit bank 0 together.
  task automatic test_same_bank();
    logic [n_masters-1:0] v;
    req_t [n_masters-1:0] r;
    master_id_t           exp_order [4];
    int                   start;
    // Bank 0 has one grant behind it, so it starts high-first.
    exp_order[0] = master_id_t'(3);
    exp_order[1] = master_id_t'(0);
    exp_order[2] = master_id_t'(2);
    exp_order[3] = master_id_t'(1);
    v     = '0;
    r     = '0;
    start = bank0_log.size();
    for (int m = 0; m < n_masters; m++) begin
      v[m]      = 1'b1;
      r[m].bank = bank_id_t'(0);
      r[m].data = 16'(32'h1100 + m);
    end
    next_cycle();
    apply_inputs(v, r);
    wait_idle();
    if (bank0_log.size() - start != 4) begin
      report_error($sformatf("%0d grants on bank 0, expected 4", bank0_log.size() - start));
    end
    for (int i = 0; i < 4; i++) begin
      if (bank0_log[start + i] !== exp_order[i]) begin
        report_error($sformatf("grant %0d went to master %0d, expected %0d",
                               i, bank0_log[start + i], exp_order[i]));
      end
    end
  endtask

  // Two banks served in the same cycle.
  task automatic test_split_banks();
    logic [n_masters-1:0] v;
    req_t [n_masters-1:0] r;
    v         = '0;
    r         = '0;
    v[0]      = 1'b1;
    r[0].bank = bank_id_t'(0);
    r[0].data = 16'h0b00;
    v[3]      = 1'b1;
    r[3].bank = bank_id_t'(1);
    r[3].data = 16'h0b13;
    next_cycle();
    apply_inputs(v, r);
    wait_idle();
    if (last_done_cycle[0] != last_done_cycle[3]) begin
      report_error("banks 0 and 1 did not grant in the same cycle");
    end
  endtask

  // Random traffic, each idle master strobes with chance 3/8.
  task automatic run_random(input int cycles);
    logic [n_masters-1:0] v;
    req_t [n_masters-1:0] r;
    for (int c = 0; c < cycles; c++) begin
      next_cycle();
      v = '0;
      r = '0;
      for (int m = 0; m < n_masters; m++) begin
        rng = lcg_next(rng);
        if (issued[m] == completed[m] && rng[31:29] < 3'd3) begin
          v[m]      = 1'b1;
          r[m].bank = bank_id_t'(int'(rng[20:13]) % n_banks);
          rng       = lcg_next(rng);
          r[m].data = rng[31 -: data_w];
        end
      end
      apply_inputs(v, r);
    end
    wait_idle();
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    req_valid = '0;
    req       = '0;
    rng       = 32'h24c9714e;
    for (int m = 0; m < n_masters; m++) begin
      issued[m]          = 0;
      completed[m]       = 0;
      last_done_cycle[m] = 0;
    end
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;

    test_single();
    test_same_bank();
    test_split_banks();
    run_random(random_cycles);
    repeat (4) next_cycle();  // No stray grants afterwards.

    $display("Result: PASSED");
    $finish;
  end

endmodule : bank_arb_tb

/* design/bank_arb_pkg.sv */
/*
  Shared widths and payload types for the bank access arbiter.
  n_masters and n_banks are the defaults that the top level passes down.
  Both must be at least 2 so that the index types have a non-zero width.
  Module parameters must not exceed these defaults, since the index types
  are sized from them.
*/

package bank_arb_pkg;

  // Subsystem size defaults.
  localparam int n_masters = 4;  // Masters posting requests.
  localparam int n_banks   = 2;  // Banks, one arbiter each.
  localparam int data_w    = 16; // Request payload width.

  // Index widths derived from the defaults.
  localparam int master_id_w = $clog2(n_masters);
  localparam int bank_id_w   = $clog2(n_banks);

  // Index of a master.
  typedef logic [master_id_w-1:0] master_id_t;

  // Index of a bank.
  typedef logic [bank_id_w-1:0] bank_id_t;

  // Request posted by a master with its strobe.
  // Bank selects the target arbiter.
  typedef struct packed {
    bank_id_t          bank;  // Target bank.
    logic [data_w-1:0] data;  // Payload passed through to the bank.
  } req_t;

  // Grant issued by one bank arbiter.
  // Master names the winner, data is its payload.
  typedef struct packed {
    master_id_t        master;  // Winning master.
    logic [data_w-1:0] data;    // Winner's payload.
  } grant_t;

  // Widths of the structs, handy for bus sizing.
  localparam int req_w   = bank_id_w + data_w;
  localparam int grant_w = master_id_w + data_w;

endpackage : bank_arb_pkg

/* design/bank_arb_top.sv */
/*
  Shared-bank access arbiter, top level.
  Requests are single-cycle strobes with no back-pressure anywhere.
  A master may strobe again only in the cycle after its done strobe.
  Uncontended latency is two cycles from the sampling edge to gnt_valid
  and done. Under contention done marks the end of the wait.
  N_MASTERS and N_BANKS must not exceed the package defaults.
*/

`timescale 1ns/1ps

module bank_arb_top
  import bank_arb_pkg::*;
#(
  parameter int N_MASTERS = n_masters,
  parameter int N_BANKS   = n_banks
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic   [N_MASTERS-1:0] req_valid,  // One strobe per master.
  input  req_t   [N_MASTERS-1:0] req,        // Sampled with the strobe.
  output logic   [N_BANKS-1:0]   gnt_valid,  // One strobe per bank.
  output grant_t [N_BANKS-1:0]   gnt,        // Grant per bank.
  output logic   [N_MASTERS-1:0] done        // Completion per master.
);

  // Capture to arbiters.
  logic [N_BANKS-1:0][N_MASTERS-1:0] bank_req;   // Request bitmap per bank.
  logic [N_BANKS-1:0][N_MASTERS-1:0] pick;       // One-hot pick per bank.
  req_t [N_MASTERS-1:0]              pend_data;  // Pending payloads.

  // Arbiters to collector.
  logic   [N_BANKS-1:0] arb_valid;  // Registered grant strobes.
  grant_t [N_BANKS-1:0] arb_gnt;    // Registered grants.

  // Pending slots and bitmap decode.
  req_capture #(
    .N_MASTERS (N_MASTERS),
    .N_BANKS   (N_BANKS)
  ) u_capture (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .pick      (pick),
    .bank_req  (bank_req),
    .pend_data (pend_data)
  );

  // One arbiter per bank.
  // All see every payload but only their own bitmap.
  for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
    bank_arbiter #(
      .N_MASTERS (N_MASTERS)
    ) u_arb (
      .clk       (clk),
      .rst_n     (rst_n),
      .bank_req  (bank_req[b]),
      .pend_data (pend_data),
      .pick      (pick[b]),
      .arb_valid (arb_valid[b]),
      .arb_gnt   (arb_gnt[b])
    );
  end

  // Output register and done decode.
  grant_collect #(
    .N_MASTERS (N_MASTERS),
    .N_BANKS   (N_BANKS)
  ) u_collect (
    .clk       (clk),
    .rst_n     (rst_n),
    .arb_valid (arb_valid),
    .arb_gnt   (arb_gnt),
    .gnt_valid (gnt_valid),
    .gnt       (gnt),
    .done      (done)
  );

endmodule : bank_arb_top

/* design/bank_arbiter.sv */
/*
  One-hot priority arbiter for a single bank.
  Picks the lowest or the highest set bit of the request bitmap.
  The search direction flips after every grant and holds while the bank
  is idle, so neither end of the bitmap starves. Low-first after reset.
  pick is combinational, the grant is registered one edge later.
  A pending request waits at most N_MASTERS-1 grants of this bank.
*/

`timescale 1ns/1ps

module bank_arbiter
  import bank_arb_pkg::*;
#(
  parameter int N_MASTERS = n_masters
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [N_MASTERS-1:0] bank_req,   // Masters pending for this bank.
  input  req_t [N_MASTERS-1:0] pend_data,  // Pending payloads of all masters.
  output logic [N_MASTERS-1:0] pick,       // One-hot winner, this cycle.
  output logic                 arb_valid,  // Registered grant strobe.
  output grant_t               arb_gnt     // Registered grant.
);

  logic       high_first;  // Search direction, 0 means lowest index wins.
  logic       deny;        // A higher priority bit was already found.
  logic       any_req;     // Bitmap non-zero.
  master_id_t win_idx;     // Binary index of the picked master.

  assign any_req = |bank_req;

  // Priority search.
  // Walk the bitmap from the favoured end and keep the first set bit.
  always_comb begin
    deny    = 1'b0;
    pick    = '0;
    win_idx = '0;
    if (high_first) begin
      for (int i = N_MASTERS - 1; i >= 0; i--) begin
        if (bank_req[i] && !deny) begin
          pick[i] = 1'b1;
          win_idx = master_id_t'(i);
        end
        deny = deny | bank_req[i];
      end
    end else begin
      for (int i = 0; i < N_MASTERS; i++) begin
        if (bank_req[i] && !deny) begin
          pick[i] = 1'b1;
          win_idx = master_id_t'(i);
        end
        deny = deny | bank_req[i];
      end
    end
  end

  // Control state.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arb_valid  <= 1'b0;
      high_first <= 1'b0;  // Low-first after reset.
    end else begin
      arb_valid <= any_req;  // One grant per busy cycle.
      if (any_req) begin
        high_first <= ~high_first;  // Flip only on a grant.
      end
    end
  end

  // Grant payload, valid only with arb_valid.
  always_ff @(posedge clk) begin
    if (any_req) begin
      arb_gnt.master <= win_idx;
      arb_gnt.data   <= pend_data[win_idx].data;
    end
  end

endmodule : bank_arbiter

/* design/grant_collect.sv */
/*
  Grant output stage.
  Registers the grants of all banks onto the subsystem outputs.
  Decodes each valid grant's master field into a done strobe for that
  master. A master has one request outstanding, so at most one bank can
  name it in a cycle. The OR across banks is only a merge.
*/

`timescale 1ns/1ps

module grant_collect
  import bank_arb_pkg::*;
#(
  parameter int N_MASTERS = n_masters,
  parameter int N_BANKS   = n_banks
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic   [N_BANKS-1:0]   arb_valid,  // Grant strobes from arbiters.
  input  grant_t [N_BANKS-1:0]   arb_gnt,    // Grants from arbiters.
  output logic   [N_BANKS-1:0]   gnt_valid,  // Registered grant strobes.
  output grant_t [N_BANKS-1:0]   gnt,        // Registered grants.
  output logic   [N_MASTERS-1:0] done        // Per-master completion strobe.
);

  logic [N_MASTERS-1:0] done_nxt;  // Done bits before the register.

  // Decode winners to masters.
  always_comb begin
    done_nxt = '0;
    for (int b = 0; b < N_BANKS; b++) begin
      for (int m = 0; m < N_MASTERS; m++) begin
        if (arb_valid[b] && (arb_gnt[b].master == master_id_t'(m))) begin
          done_nxt[m] = 1'b1;
        end
      end
    end
  end

  // Strobes.
  // gnt_valid and done share the same edge.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_valid <= '0;
      done      <= '0;
    end else begin
      gnt_valid <= arb_valid;
      done      <= done_nxt;
    end
  end

  // Payload.
  // Each bank's grant is loaded only when that bank granted.
  always_ff @(posedge clk) begin
    for (int b = 0; b < N_BANKS; b++) begin
      if (arb_valid[b]) begin
        gnt[b] <= arb_gnt[b];
      end
    end
  end

endmodule : grant_collect

/* design/req_capture.sv */
/*
  Request capture stage.
  One pending slot per master, loaded on the master's strobe.
  A master must not strobe while its slot is pending. The slot is
  cleared at the edge that ends a cycle in which any bank picks it.
  The per-bank request bitmaps are decoded combinationally from the
  pending slots, so a new request is visible in the cycle after sampling.
*/

`timescale 1ns/1ps

module req_capture
  import bank_arb_pkg::*;
#(
  parameter int N_MASTERS = n_masters,
  parameter int N_BANKS   = n_banks
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [N_MASTERS-1:0]               req_valid,  // Request strobes.
  input  req_t [N_MASTERS-1:0]               req,        // Request payloads.
  input  logic [N_BANKS-1:0][N_MASTERS-1:0]  pick,       // One-hot pick per bank.
  output logic [N_BANKS-1:0][N_MASTERS-1:0]  bank_req,   // Request bitmap per bank.
  output req_t [N_MASTERS-1:0]               pend_data   // Pending slot contents.
);

  logic [N_MASTERS-1:0] pending;  // Slot holds an ungranted request.
  logic [N_MASTERS-1:0] picked;   // Some bank picked this master now.
  req_t [N_MASTERS-1:0] slot;     // Captured request per master.

  // Merge the picks of all banks.
  // Each master sits in at most one bank bitmap, so at most one bank
  // can name it in any cycle.
  always_comb begin
    picked = '0;
    for (int b = 0; b < N_BANKS; b++) begin
      picked = picked | pick[b];
    end
  end

  // Pending bits.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      for (int m = 0; m < N_MASTERS; m++) begin
        if (req_valid[m]) begin
          pending[m] <= 1'b1;  // New request.
        end else if (picked[m]) begin
          pending[m] <= 1'b0;  // Granted this cycle.
        end
      end
    end
  end

  // Slot payload.
  // Only loaded on a strobe, held until the next one.
  always_ff @(posedge clk) begin
    for (int m = 0; m < N_MASTERS; m++) begin
      if (req_valid[m]) begin
        slot[m] <= req[m];
      end
    end
  end

  // Decode each pending slot into its bank's bitmap.
  always_comb begin
    bank_req = '0;
    for (int b = 0; b < N_BANKS; b++) begin
      for (int m = 0; m < N_MASTERS; m++) begin
        bank_req[b][m] = pending[m] && (slot[m].bank == bank_id_t'(b));
      end
    end
  end

  // Arbiters read the payload directly from the slots.
  assign pend_data = slot;

endmodule : req_capture

/* filelist.f */
design/bank_arb_pkg.sv
design/req_capture.sv
design/bank_arbiter.sv
design/grant_collect.sv
design/bank_arb_top.sv
bench/bank_arb_asserts.sv
bench/bank_arb_tb.sv

/* run.sh */
#!/bin/sh
# Builds the bank arbiter testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module bank_arb_tb -f filelist.f

status=0
./obj_dir/Vbank_arb_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "Simulation failed."
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  echo "Simulation ended without a result, exit status $status."
  exit 1
fi
echo "Simulation passed."
